// File: boothMultiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "mulDiv_defines.svh"

module boothMultiplier (
	input  logic Clock,
	input  logic rstN,
	input  logic start,
	input  logic [`MULDIV_WIDTH-1:0] multiplicand,
	input  logic [`MULDIV_WIDTH-1:0] multiplier,
	output logic done,
	output mulDivPkg::hiLo result
);
	localparam int W = `MULDIV_WIDTH;
	localparam int CntW = $clog2(`MULDIV_STEPS);

	// the accumulator carries one guard bit so that adding or subtracting
	// the most negative multiplicand cannot overflow.
	logic [W:0] acc;
	logic [W-1:0] mq;
	logic mqExtra;
	logic [W:0] mcand;
	logic [W:0] sum;
	logic [CntW-1:0] count;
	logic running;

	always_comb begin
		case ({mq[0], mqExtra})
			2'b01: sum = acc + mcand;
			2'b10: sum = acc - mcand;
			default: sum = acc;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (start) begin
			acc <= '0;
			mq <= multiplier;
			mqExtra <= 1'b0;
			mcand <= {multiplicand[W-1], multiplicand};
		end else if (running) begin
			// arithmetic shift right of the whole {acc, mq, mqExtra} chain.
			acc <= {sum[W], sum[W:1]};
			mq <= {sum[0], mq[W-1:1]};
			mqExtra <= mq[0];
		end
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			running <= 1'b0;
			count <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				count <= '0;
			end else if (running) begin
				count <= count + 1'b1;
				if (count == CntW'(`MULDIV_STEPS - 1)) begin
					running <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// the product sits in the shift chain once the last step is done.
	assign result.hi = acc[W-1:0];
	assign result.lo = mq;

	// the top level drops a CTRL write while busy, so no start overlaps a run.
	assert property (@(posedge Clock) disable iff (!rstN) running |-> !start)
		else $error("multiplier started while running");

endmodule

`default_nettype wire

// File: hiLoCombiner.sv
`timescale 1ns/1ps
`default_nettype none

module hiLoCombiner (
	input  logic Clock,
	input  logic rstN,
	input  logic start,
	input  logic mulDone,
	input  mulDivPkg::hiLo mulResult,
	input  logic divDone,
	input  mulDivPkg::hiLo divResult,
	input  logic divZero,
	output logic busy,
	output mulDivPkg::hiLo held,
	output logic heldDivZero
);

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			busy <= 1'b0;
		end else if (start) begin
			busy <= 1'b1;
		end else if (mulDone || divDone) begin
			busy <= 1'b0;
		end
	end

	// a multiply done clears the divide-by-zero flag.
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			held <= '0;
			heldDivZero <= 1'b0;
		end else if (mulDone) begin
			held <= mulResult;
			heldDivZero <= 1'b0;
		end else if (divDone) begin
			held <= divResult;
			heldDivZero <= divZero;
		end
	end

	// only one operation is ever in flight, so the units never finish together.
	assert property (@(posedge Clock) disable iff (!rstN) !(mulDone && divDone))
		else $error("multiplier and divider finished in the same cycle");

endmodule

`default_nettype wire

// File: mulDivPkg.sv
`default_nettype none

`include "mulDiv_defines.svh"

package mulDivPkg;

	// operation selected by bit 0 of a CTRL write.
	typedef enum logic {
		OpMul = 1'b0,
		OpDiv = 1'b1
	} mulDivOp;

	// master to slave side of the Wishbone classic bus.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [4:0] adr;
		logic [`MULDIV_WIDTH-1:0] datW;
	} wbReq;

	// slave to master side.
	typedef struct packed {
		logic [`MULDIV_WIDTH-1:0] datR;
		logic ack;
	} wbRsp;

	// a multiply gives the upper and lower product halves here,
	// a divide gives the remainder in hi and the quotient in lo.
	typedef struct packed {
		logic [`MULDIV_WIDTH-1:0] hi;
		logic [`MULDIV_WIDTH-1:0] lo;
	} hiLo;

endpackage

`default_nettype wire

// File: mulDivUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mulDiv_defines.svh"

module mulDivUnit (
	input  logic Clock,
	input  logic rstN,
	input  mulDivPkg::wbReq wbIn,
	output mulDivPkg::wbRsp wbOut
);
	import mulDivPkg::*;

	localparam int W = `MULDIV_WIDTH;

	logic [W-1:0] opA;
	logic [W-1:0] opB;
	logic ack;
	logic [W-1:0] datR;
	logic [W-1:0] rdMux;
	logic [2:0] wordAdr;
	logic reqNew;
	logic wrNew;
	mulDivOp op;
	logic start;
	logic startMul;
	logic startDiv;
	logic mulDone;
	logic divDone;
	logic divZero;
	hiLo mulResult;
	hiLo divResult;
	hiLo held;
	logic busy;
	logic heldDivZero;

	// a request counts once, in the cycle before its ack.
	assign reqNew = wbIn.cyc && wbIn.stb && !ack;
	assign wrNew = reqNew && wbIn.we;
	assign wordAdr = wbIn.adr[4:2];

	assign op = mulDivOp'(wbIn.datW[0]);
	assign start = wrNew && (wordAdr == `ADR_CTRL) && !busy;
	assign startMul = start && (op == OpMul);
	assign startDiv = start && (op == OpDiv);

	always_comb begin
		case (wordAdr)
			`ADR_OPA: rdMux = opA;
			`ADR_OPB: rdMux = opB;
			`ADR_STATUS: rdMux = {{(W-2){1'b0}}, heldDivZero, busy};
			`ADR_LO: rdMux = held.lo;
			`ADR_HI: rdMux = held.hi;
			default: rdMux = '0;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			ack <= 1'b0;
			datR <= '0;
			opA <= '0;
			opB <= '0;
		end else begin
			ack <= reqNew;
			if (reqNew && !wbIn.we) begin
				datR <= rdMux;
			end
			if (wrNew && wordAdr == `ADR_OPA) begin
				opA <= wbIn.datW;
			end
			if (wrNew && wordAdr == `ADR_OPB) begin
				opB <= wbIn.datW;
			end
		end
	end

	assign wbOut.datR = datR;
	assign wbOut.ack = ack;

	boothMultiplier boothMultiplier_inst (
		.Clock(Clock),
		.rstN(rstN),
		.start(startMul),
		.multiplicand(opA),
		.multiplier(opB),
		.done(mulDone),
		.result(mulResult)
	);

	restoringDivider restoringDivider_inst (
		.Clock(Clock),
		.rstN(rstN),
		.start(startDiv),
		.dividend(opA),
		.divisor(opB),
		.done(divDone),
		.divZero(divZero),
		.result(divResult)
	);

	hiLoCombiner hiLoCombiner_inst (
		.Clock(Clock),
		.rstN(rstN),
		.start(start),
		.mulDone(mulDone),
		.mulResult(mulResult),
		.divDone(divDone),
		.divResult(divResult),
		.divZero(divZero),
		.busy(busy),
		.held(held),
		.heldDivZero(heldDivZero)
	);

	assert property (@(posedge Clock) disable iff (!rstN)
		ack |-> $past(wbIn.cyc && wbIn.stb))
		else $error("ack without a preceding request");

endmodule

`default_nettype wire

// File: mulDiv_defines.svh
`ifndef MULDIV_DEFINES_SVH
`define MULDIV_DEFINES_SVH

// operand width of the multiplier and divider.
`define MULDIV_WIDTH 32

// one iteration per operand bit in both units.
`define MULDIV_STEPS 32

// word addresses are compared against bus address bits 4 to 2.
`define ADR_OPA    3'd0
`define ADR_OPB    3'd1
`define ADR_CTRL   3'd2
`define ADR_STATUS 3'd3
`define ADR_LO     3'd4
`define ADR_HI     3'd5

`endif

// File: project.f
+incdir+.
mulDivPkg.sv
boothMultiplier.sv
restoringDivider.sv
hiLoCombiner.sv
mulDivUnit.sv
tbMulDiv.sv

// File: restoringDivider.sv
`timescale 1ns/1ps
`default_nettype none

`include "mulDiv_defines.svh"

module restoringDivider (
	input  logic Clock,
	input  logic rstN,
	input  logic start,
	input  logic [`MULDIV_WIDTH-1:0] dividend,
	input  logic [`MULDIV_WIDTH-1:0] divisor,
	output logic done,
	output logic divZero,
	output mulDivPkg::hiLo result
);
	localparam int W = `MULDIV_WIDTH;
	localparam int CntW = $clog2(`MULDIV_STEPS);

	logic [W-1:0] rem;
	logic [W-1:0] quo;
	logic [W-1:0] dvs;
	logic negQuo;
	logic negRem;
	logic [W:0] shifted;
	logic [W:0] trial;
	logic [W-1:0] resHi;
	logic [W-1:0] resLo;
	logic [CntW-1:0] count;
	logic running;
	logic fixup;

	assign shifted = {rem, quo[W-1]};
	assign trial = shifted - {1'b0, dvs};

	always_ff @(posedge Clock) begin
		if (start) begin
			// work on magnitudes and remember the signs for the fixup cycle.
			rem <= '0;
			quo <= dividend[W-1] ? -dividend : dividend;
			dvs <= divisor[W-1] ? -divisor : divisor;
			negQuo <= dividend[W-1] ^ divisor[W-1];
			negRem <= dividend[W-1];
			if (divisor == '0) begin
				resHi <= '0;
				resLo <= '0;
			end
		end else if (running) begin
			if (!trial[W]) begin
				rem <= trial[W-1:0];
				quo <= {quo[W-2:0], 1'b1};
			end else begin
				rem <= shifted[W-1:0];
				quo <= {quo[W-2:0], 1'b0};
			end
		end else if (fixup) begin
			// the remainder takes the sign of the dividend as truncating division requires.
			resLo <= negQuo ? -quo : quo;
			resHi <= negRem ? -rem : rem;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			running <= 1'b0;
			fixup <= 1'b0;
			count <= '0;
			done <= 1'b0;
			divZero <= 1'b0;
		end else begin
			done <= 1'b0;
			divZero <= 1'b0;
			fixup <= 1'b0;
			if (start) begin
				if (divisor == '0) begin
					done <= 1'b1;
					divZero <= 1'b1;
				end else begin
					running <= 1'b1;
					count <= '0;
				end
			end else if (running) begin
				count <= count + 1'b1;
				if (count == CntW'(`MULDIV_STEPS - 1)) begin
					running <= 1'b0;
					fixup <= 1'b1;
				end
			end else if (fixup) begin
				done <= 1'b1;
			end
		end
	end

	assign result.hi = resHi;
	assign result.lo = resLo;

	assert property (@(posedge Clock) disable iff (!rstN) (running || fixup) |-> !start)
		else $error("divider started while running");

	assert property (@(posedge Clock) disable iff (!rstN) divZero |-> done)
		else $error("divZero raised without done");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; a nonzero exit means failure.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbMulDiv \
	-f project.f \
	-o simMulDiv

./obj_dir/simMulDiv

// File: tbMulDiv.sv
`timescale 1ns/1ps
`default_nettype none

`include "mulDiv_defines.svh"

module tbMulDiv;
	import mulDivPkg::*;

	localparam int RandomOps = 60;
	localparam int DirectedOps = 7;
	localparam int OpCycles = 60;
	localparam int MarginCycles = 400;
	localparam int TimeoutCycles = (RandomOps + DirectedOps) * OpCycles + MarginCycles;

	logic Clock;
	logic rstN;
	wbReq wbIn;
	wbRsp wbOut;
	logic [31:0] lfsrState;
	logic [31:0] lastA;
	logic [31:0] lastB;

	mulDivUnit mulDivUnit_inst (
		.Clock(Clock),
		.rstN(rstN),
		.wbIn(wbIn),
		.wbOut(wbOut)
	);

	initial begin
		Clock = 1'b0;
		forever #4 Clock = ~Clock;
	end

	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped after an error");
	endtask

	initial begin
		repeat (TimeoutCycles) @(posedge Clock);
		stopRun($sformatf("the run timed out after %0d cycles", TimeoutCycles));
	end

	// right-shifting Galois LFSR with taps 32, 30, 26 and 25.
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'hA300_0000;
		end else begin
			return state >> 1;
		end
	endfunction

	task automatic randomBits(input int n, output logic [31:0] value);
		value = '0;
		for (int k = 0; k < n; k++) begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
	endtask

	// the model gives the signed product, or the truncating quotient in lo
	// and the remainder in hi.
	function automatic hiLo modelResult(input mulDivOp op, input logic [31:0] a,
			input logic [31:0] b);
		longint sa;
		longint sb;
		longint full;
		longint quo;
		longint rem;
		hiLo r;
		sa = $signed(a);
		sb = $signed(b);
		r = '0;
		if (op == OpMul) begin
			full = sa * sb;
			r.hi = full[63:32];
			r.lo = full[31:0];
		end else if (b != '0) begin
			quo = sa / sb;
			rem = sa % sb;
			r.hi = rem[31:0];
			r.lo = quo[31:0];
		end
		return r;
	endfunction

	task automatic checkHiLo(input hiLo got, input hiLo exp, input string what);
		if (got !== exp) begin
			stopRun($sformatf("FAILED at %0t: %s gave hi %h lo %h, expected hi %h lo %h",
				$time, what, got.hi, got.lo, exp.hi, exp.lo));
		end
	endtask

	task automatic checkStatus(input logic [31:0] got, input logic expDivZero,
			input string what);
		logic [31:0] exp;
		exp = {30'b0, expDivZero, 1'b0};
		if (got !== exp) begin
			stopRun($sformatf("FAILED at %0t: %s status %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic checkWord(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		if (got !== exp) begin
			stopRun($sformatf("FAILED at %0t: %s read %h, expected %h", $time, what, got, exp));
		end
	endtask

	// one classic cycle in which the ack must come and then go low again.
	task automatic busAccess(input logic we, input logic [2:0] word, input logic [31:0] wdata,
			output logic [31:0] rdata);
		wbReq req;
		int waitCycles;
		req = '0;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = we;
		req.adr = {word, 2'b00};
		req.datW = wdata;
		waitCycles = 0;
		@(posedge Clock);
		wbIn <= req;
		@(negedge Clock);
		while (wbOut.ack !== 1'b1) begin
			waitCycles++;
			if (waitCycles > 4) begin
				stopRun($sformatf("no ack came for the access to word %0d", word));
			end
			@(negedge Clock);
		end
		rdata = wbOut.datR;
		@(posedge Clock);
		wbIn <= '0;
		@(negedge Clock);
		if (wbOut.ack !== 1'b0) begin
			stopRun($sformatf("the access to word %0d was acknowledged twice", word));
		end
	endtask

	task automatic writeReg(input logic [2:0] word, input logic [31:0] data);
		logic [31:0] unused;
		busAccess(1'b1, word, data, unused);
	endtask

	task automatic readReg(input logic [2:0] word, output logic [31:0] data);
		busAccess(1'b0, word, '0, data);
	endtask

	task automatic waitIdle();
		logic [31:0] status;
		readReg(`ADR_STATUS, status);
		while (status[0]) begin
			readReg(`ADR_STATUS, status);
		end
	endtask

	task automatic runOp(input mulDivOp op, input logic [31:0] a, input logic [31:0] b,
			input logic disturb, input string what);
		logic [31:0] lo;
		logic [31:0] hi;
		logic [31:0] status;
		logic [31:0] junk;
		hiLo got;
		writeReg(`ADR_OPA, a);
		writeReg(`ADR_OPB, b);
		writeReg(`ADR_CTRL, {31'b0, op == OpDiv});
		lastA = a;
		lastB = b;
		if (disturb) begin
			// a second start and new operands while the first operation is still running.
			randomBits(32, junk);
			writeReg(`ADR_CTRL, {31'b0, op == OpMul});
			writeReg(`ADR_OPA, junk);
			writeReg(`ADR_OPB, ~junk);
			lastA = junk;
			lastB = ~junk;
		end
		waitIdle();
		readReg(`ADR_LO, lo);
		readReg(`ADR_HI, hi);
		readReg(`ADR_STATUS, status);
		got.hi = hi;
		got.lo = lo;
		checkHiLo(got, modelResult(op, a, b), what);
		checkStatus(status, op == OpDiv && b == '0, what);
	endtask

	initial begin
		logic [31:0] data;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sel;
		mulDivOp op;
		lfsrState = 32'h7a89_2643;
		wbIn = '0;
		rstN = 1'b0;
		repeat (3) @(posedge Clock);
		rstN <= 1'b1;

		readReg(`ADR_STATUS, data);
		checkStatus(data, 1'b0, "status after reset");
		readReg(`ADR_HI, data);
		checkWord(data, '0, "HI after reset");
		readReg(`ADR_LO, data);
		checkWord(data, '0, "LO after reset");

		runOp(OpMul, 32'h8000_0000, 32'h8000_0000, 1'b0, "most negative squared");
		runOp(OpDiv, 32'h8000_0000, 32'hFFFF_FFFF, 1'b0, "most negative over minus one");
		runOp(OpDiv, -32'sd7, 32'sd2, 1'b0, "minus seven over two");

		// a divide by zero is followed by a multiply that must clear the flag.
		randomBits(32, a);
		runOp(OpDiv, a, '0, 1'b0, "divide by zero");
		randomBits(32, b);
		runOp(OpMul, a, b, 1'b0, "multiply after divide by zero");

		randomBits(32, a);
		randomBits(32, b);
		runOp(OpMul, a, b, 1'b1, "multiply with writes while busy");
		randomBits(32, a);
		randomBits(16, b);
		runOp(OpDiv, a, b | 32'h1, 1'b1, "divide with writes while busy");

		for (int i = 0; i < RandomOps; i++) begin
			randomBits(1, sel);
			op = mulDivOp'(sel[0]);
			randomBits(32, a);
			if (op == OpMul) begin
				randomBits(32, b);
			end else begin
				randomBits(3, sel);
				case (sel[2:0])
					3'd0: b = '0;
					3'd1: begin
						randomBits(4, b);
						b = b + 32'd1;
					end
					3'd2: begin
						randomBits(4, b);
						b = -(b + 32'd1);
					end
					default: randomBits(32, b);
				endcase
			end
			runOp(op, a, b, 1'b0, $sformatf("random op %0d", i));
		end

		readReg(`ADR_OPA, data);
		checkWord(data, lastA, "OPA read-back");
		readReg(`ADR_OPB, data);
		checkWord(data, lastB, "OPB read-back");
		readReg(`ADR_CTRL, data);
		checkWord(data, '0, "CTRL read");
		readReg(3'd6, data);
		checkWord(data, '0, "unmapped word 6");
		readReg(3'd7, data);
		checkWord(data, '0, "unmapped word 7");

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire
